//--- verilog/mips_exe_pkg.sv
`default_nettype none

package mips_exe_pkg;

	////////////////////
	// Widths
	////////////////////
	localparam int WORD_W = 32;
	localparam int REG_IDX_W = 5;

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	////////////////////
	// Encodings
	////////////////////

	// Operation carried from decode into execute
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI,
		ALU_LINK,
		ALU_MUL,
		ALU_NOP
	} alu_op_t;

	typedef enum logic [1:0] {
		EXC_NONE,
		EXC_RI
	} exc_code_t;

	// Execute slot occupancy
	typedef enum logic [1:0] {
		ST_EMPTY,
		ST_FULL,
		ST_MUL
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- verilog/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder (
	input  logic [31:0]               instr,
	output mips_exe_pkg::alu_op_t     alu_op,
	output logic [15:0]               imm,
	output logic                      use_imm,
	output logic                      imm_sign,
	output logic [4:0]                shamt,
	output mips_exe_pkg::reg_idx_t    dest,
	output logic                      we,
	output mips_exe_pkg::exc_code_t   exc
);
	import mips_exe_pkg::*;

	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI = 6'h0a;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_SPECIAL2 = 6'h1c;

	logic [5:0] opcode;
	logic [5:0] funct;
	logic       legal;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign imm = instr[15:0];
	assign shamt = instr[10:6];

	always_comb begin
		alu_op = ALU_NOP;
		use_imm = 1'b0;
		imm_sign = 1'b0;
		legal = 1'b1;
		// rd by default, rt for the immediate group
		dest = instr[15:11];
		if (opcode[5:3] == 3'b001) begin
			use_imm = 1'b1;
			dest = instr[20:16];
		end
		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					6'h00: alu_op = ALU_SLL;
					6'h02: alu_op = ALU_SRL;
					6'h03: alu_op = ALU_SRA;
					6'h21: alu_op = ALU_ADD;
					6'h23: alu_op = ALU_SUB;
					6'h24: alu_op = ALU_AND;
					6'h25: alu_op = ALU_OR;
					6'h26: alu_op = ALU_XOR;
					6'h27: alu_op = ALU_NOR;
					6'h2a: alu_op = ALU_SLT;
					6'h2b: alu_op = ALU_SLTU;
					default: legal = 1'b0;
				endcase
			end
			// MUL is the only SPECIAL2 function handled
			OP_SPECIAL2: begin
				if (funct == 6'h02) begin
					alu_op = ALU_MUL;
				end else begin
					legal = 1'b0;
				end
			end
			OP_JAL: begin
				alu_op = ALU_LINK;
				dest = 5'd31;
			end
			OP_ADDIU: begin
				alu_op = ALU_ADD;
				imm_sign = 1'b1;
			end
			OP_SLTI: begin
				alu_op = ALU_SLT;
				imm_sign = 1'b1;
			end
			OP_ANDI: alu_op = ALU_AND;
			OP_ORI: alu_op = ALU_OR;
			OP_XORI: alu_op = ALU_XOR;
			OP_LUI: alu_op = ALU_LUI;
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			alu_op = ALU_NOP;
			use_imm = 1'b0;
			imm_sign = 1'b0;
			dest = '0;
		end
		// Writes to r0 are dropped here
		we = legal && (dest != '0);
		exc = legal ? EXC_NONE : EXC_RI;
	end

endmodule

`default_nettype wire

//--- verilog/id_exe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module id_exe_reg (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 en,
	input  logic                                 bubble,
	input  mips_exe_pkg::alu_op_t                alu_op,
	input  logic [15:0]                          imm,
	input  logic                                 use_imm,
	input  logic                                 imm_sign,
	input  logic [4:0]                           shamt,
	input  mips_exe_pkg::reg_idx_t               dest,
	input  logic                                 we,
	input  mips_exe_pkg::exc_code_t              exc,
	input  logic [mips_exe_pkg::WORD_W-1:0]      rega,
	input  logic [mips_exe_pkg::WORD_W-1:0]      regb,
	input  logic [mips_exe_pkg::WORD_W-1:0]      pc,
	output logic                                 exe_valid,
	output mips_exe_pkg::alu_op_t                exe_alu_op,
	output logic [15:0]                          exe_imm,
	output logic                                 exe_use_imm,
	output logic                                 exe_imm_sign,
	output logic [4:0]                           exe_shamt,
	output mips_exe_pkg::reg_idx_t               exe_dest,
	output logic                                 exe_we,
	output mips_exe_pkg::exc_code_t              exe_exc,
	output logic [mips_exe_pkg::WORD_W-1:0]      exe_rega,
	output logic [mips_exe_pkg::WORD_W-1:0]      exe_regb,
	output logic [mips_exe_pkg::WORD_W-1:0]      exe_pc
);
	import mips_exe_pkg::*;

	// Bubble wipes the whole slot, exception code included
	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			exe_valid <= 1'b0;
			exe_alu_op <= ALU_ADD;
			exe_imm <= '0;
			exe_use_imm <= 1'b0;
			exe_imm_sign <= 1'b0;
			exe_shamt <= '0;
			exe_dest <= '0;
			exe_we <= 1'b0;
			exe_exc <= EXC_NONE;
			exe_rega <= '0;
			exe_regb <= '0;
			exe_pc <= '0;
		end else if (en) begin
			exe_valid <= 1'b1;
			exe_alu_op <= alu_op;
			exe_imm <= imm;
			exe_use_imm <= use_imm;
			exe_imm_sign <= imm_sign;
			exe_shamt <= shamt;
			exe_dest <= dest;
			exe_we <= we;
			exe_exc <= exc;
			exe_rega <= rega;
			exe_regb <= regb;
			exe_pc <= pc;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mul_step_counter.sv
`timescale 1ns/10ps
`default_nettype none

module mul_step_counter #(
	parameter int MUL_CYCLES = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic step,
	output logic last
);

	// At least one bit, even for a single-step multiply
	localparam int CNT_W = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (start) begin
			count <= CNT_W'(MUL_CYCLES - 1);
		end else if (step && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	// Step taken at zero is the final one
	assign last = (count == '0);

endmodule

`default_nettype wire

//--- verilog/exe_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exe_alu #(
	parameter int MUL_CYCLES = 4
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               mul_start,
	input  logic                               mul_step,
	input  mips_exe_pkg::alu_op_t              alu_op,
	input  logic [mips_exe_pkg::WORD_W-1:0]    rega,
	input  logic [mips_exe_pkg::WORD_W-1:0]    regb,
	input  logic [15:0]                        imm,
	input  logic                               use_imm,
	input  logic                               imm_sign,
	input  logic [4:0]                         shamt,
	input  logic [mips_exe_pkg::WORD_W-1:0]    pc,
	output logic [mips_exe_pkg::WORD_W-1:0]    result
);
	import mips_exe_pkg::*;

	// Multiplier bits consumed per step
	localparam int SLICE_W = WORD_W / MUL_CYCLES;
	localparam int IDX_W = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;

	logic [WORD_W-1:0]  ext_imm;
	logic [WORD_W-1:0]  opb;
	logic [WORD_W-1:0]  acc;
	logic [IDX_W-1:0]   step_idx;
	logic [SLICE_W-1:0] mplier_slice;
	logic [WORD_W-1:0]  partial;

	assign ext_imm = imm_sign ? {{(WORD_W-16){imm[15]}}, imm} : {{(WORD_W-16){1'b0}}, imm};
	assign opb = use_imm ? ext_imm : regb;

	////////////////////
	// Shift-add multiplier
	////////////////////

	// Operands stay put in the stage register while the multiply runs
	assign mplier_slice = regb[step_idx*SLICE_W +: SLICE_W];
	assign partial = (rega * WORD_W'(mplier_slice)) << (step_idx * SLICE_W);

	always_ff @(posedge clk) begin
		if (rst || mul_start) begin
			step_idx <= '0;
		end else if (mul_step) begin
			step_idx <= step_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_start) begin
			acc <= '0;
		end else if (mul_step) begin
			acc <= acc + partial;
		end
	end

	////////////////////
	// Result select
	////////////////////
	always_comb begin
		case (alu_op)
			ALU_ADD: result = rega + opb;
			ALU_SUB: result = rega - opb;
			ALU_AND: result = rega & opb;
			ALU_OR: result = rega | opb;
			ALU_XOR: result = rega ^ opb;
			ALU_NOR: result = ~(rega | opb);
			ALU_SLT: result = {{(WORD_W-1){1'b0}}, $signed(rega) < $signed(opb)};
			ALU_SLTU: result = {{(WORD_W-1){1'b0}}, rega < opb};
			// Shifts take the amount from the instruction
			ALU_SLL: result = regb << shamt;
			ALU_SRL: result = regb >> shamt;
			ALU_SRA: result = $signed(regb) >>> shamt;
			ALU_LUI: result = {imm, {(WORD_W-16){1'b0}}};
			// Return address skips the delay slot
			ALU_LINK: result = pc + WORD_W'(8);
			ALU_MUL: result = acc;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/exe_stage_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module exe_stage_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  logic                  out_ready,
	input  logic                  stage_valid,
	input  mips_exe_pkg::alu_op_t dec_op,
	input  logic                  mul_last,
	output logic                  in_ready,
	output logic                  out_valid,
	output logic                  stage_en,
	output logic                  stage_bubble,
	output logic                  mul_start,
	output logic                  mul_step
);
	import mips_exe_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_EMPTY;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		in_ready = 1'b0;
		out_valid = 1'b0;
		mul_step = 1'b0;
		stage_bubble = 1'b0;
		state_next = state;
		case (state)
			ST_EMPTY: in_ready = 1'b1;
			ST_MUL: begin
				mul_step = 1'b1;
				if (mul_last) begin
					state_next = ST_FULL;
				end
			end
			ST_FULL: begin
				out_valid = stage_valid;
				// Slot frees up on retire, or if it was already flushed
				in_ready = out_ready || !stage_valid;
				if (in_ready && !in_valid) begin
					stage_bubble = stage_valid;
					state_next = ST_EMPTY;
				end
			end
			default: state_next = ST_EMPTY;
		endcase
		if (in_ready && in_valid) begin
			state_next = (dec_op == ALU_MUL) ? ST_MUL : ST_FULL;
		end
	end

	// Accumulator clears on the same edge the MUL is loaded
	assign stage_en = in_ready && in_valid;
	assign mul_start = stage_en && (dec_op == ALU_MUL);

endmodule

`default_nettype wire

//--- verilog/exe_slice_top.sv
`timescale 1ns/10ps
`default_nettype none

module exe_slice_top #(
	parameter int MUL_CYCLES = 4
) (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               in_valid,
	output logic                               in_ready,
	input  logic [mips_exe_pkg::WORD_W-1:0]    instr,
	input  logic [mips_exe_pkg::WORD_W-1:0]    in_pc,
	input  logic [mips_exe_pkg::WORD_W-1:0]    rega,
	input  logic [mips_exe_pkg::WORD_W-1:0]    regb,
	output logic                               out_valid,
	input  logic                               out_ready,
	output logic [mips_exe_pkg::WORD_W-1:0]    result,
	output mips_exe_pkg::reg_idx_t             dreg,
	output logic                               we,
	output mips_exe_pkg::exc_code_t            exc,
	output logic [mips_exe_pkg::WORD_W-1:0]    out_pc
);
	import mips_exe_pkg::*;

	// Decode outputs
	alu_op_t     dec_op;
	logic [15:0] dec_imm;
	logic        dec_use_imm, dec_imm_sign, dec_we;
	logic [4:0]  dec_shamt;
	reg_idx_t    dec_dest;
	exc_code_t   dec_exc;

	// Execute slot
	logic              stage_valid;
	alu_op_t           exe_op;
	logic [15:0]       exe_imm;
	logic              exe_use_imm, exe_imm_sign;
	logic [4:0]        exe_shamt;
	logic [WORD_W-1:0] exe_rega, exe_regb;

	logic stage_en, stage_bubble, mul_start, mul_step, mul_last;

	inst_decoder u_dec (
		.instr(instr), .alu_op(dec_op), .imm(dec_imm), .use_imm(dec_use_imm),
		.imm_sign(dec_imm_sign), .shamt(dec_shamt), .dest(dec_dest),
		.we(dec_we), .exc(dec_exc)
	);

	id_exe_reg u_stage (
		.clk(clk), .rst(rst), .en(stage_en), .bubble(stage_bubble),
		.alu_op(dec_op), .imm(dec_imm), .use_imm(dec_use_imm), .imm_sign(dec_imm_sign),
		.shamt(dec_shamt), .dest(dec_dest), .we(dec_we), .exc(dec_exc),
		.rega(rega), .regb(regb), .pc(in_pc),
		.exe_valid(stage_valid), .exe_alu_op(exe_op), .exe_imm(exe_imm),
		.exe_use_imm(exe_use_imm), .exe_imm_sign(exe_imm_sign), .exe_shamt(exe_shamt),
		.exe_dest(dreg), .exe_we(we), .exe_exc(exc),
		.exe_rega(exe_rega), .exe_regb(exe_regb), .exe_pc(out_pc)
	);

	exe_stage_ctrl u_ctrl (
		.clk(clk), .rst(rst), .in_valid(in_valid), .out_ready(out_ready),
		.stage_valid(stage_valid), .dec_op(dec_op), .mul_last(mul_last),
		.in_ready(in_ready), .out_valid(out_valid), .stage_en(stage_en),
		.stage_bubble(stage_bubble), .mul_start(mul_start), .mul_step(mul_step)
	);

	mul_step_counter #(.MUL_CYCLES(MUL_CYCLES)) u_cnt (
		.clk(clk), .rst(rst), .start(mul_start), .step(mul_step), .last(mul_last)
	);

	exe_alu #(.MUL_CYCLES(MUL_CYCLES)) u_alu (
		.clk(clk), .rst(rst), .mul_start(mul_start), .mul_step(mul_step),
		.alu_op(exe_op), .rega(exe_rega), .regb(exe_regb), .imm(exe_imm),
		.use_imm(exe_use_imm), .imm_sign(exe_imm_sign), .shamt(exe_shamt),
		.pc(out_pc), .result(result)
	);

endmodule

`default_nettype wire

//--- testbench/tb_exe_slice.sv
`timescale 1ns/10ps
`default_nettype none

module tb_exe_slice;
	import mips_exe_pkg::*;

	localparam int MUL_CYCLES = 4;
	localparam int N_INSTR = 400;
	localparam int IDLE_LIMIT = 200;

	typedef struct packed {
		logic [WORD_W-1:0] result;
		reg_idx_t          dreg;
		logic              we;
		exc_code_t         exc;
		logic [WORD_W-1:0] pc;
		logic              legal;
	} expect_t;

	logic              clk;
	logic              rst;
	logic              in_valid;
	logic              in_ready;
	logic [WORD_W-1:0] instr;
	logic [WORD_W-1:0] in_pc;
	logic [WORD_W-1:0] rega;
	logic [WORD_W-1:0] regb;
	logic              out_valid;
	logic              out_ready;
	logic [WORD_W-1:0] result;
	reg_idx_t          dreg;
	logic              we;
	exc_code_t         exc;
	logic [WORD_W-1:0] out_pc;

	logic [31:0] lfsr;
	expect_t     exp_q[$];
	int          err_value;
	int          err_other;

	exe_slice_top #(.MUL_CYCLES(MUL_CYCLES)) uut (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
		.instr(instr), .in_pc(in_pc), .rega(rega), .regb(regb),
		.out_valid(out_valid), .out_ready(out_ready), .result(result),
		.dreg(dreg), .we(we), .exc(exc), .out_pc(out_pc)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Random source
	////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// Supported funct codes at 0..10, supported I-type opcodes at 11..16
	function automatic logic [5:0] code_pick(input int sel);
		case (sel)
			0: return 6'h00;
			1: return 6'h02;
			2: return 6'h03;
			3: return 6'h21;
			4: return 6'h23;
			5: return 6'h24;
			6: return 6'h25;
			7: return 6'h26;
			8: return 6'h27;
			9: return 6'h2a;
			10: return 6'h2b;
			11: return 6'h09;
			12: return 6'h0a;
			13: return 6'h0c;
			14: return 6'h0d;
			15: return 6'h0e;
			16: return 6'h0f;
			default: return 6'h00;
		endcase
	endfunction

	task automatic drive_instruction();
		logic [31:0] kind;
		logic [31:0] word;
		kind = rand_bits(4);
		word = rand_bits(32);
		if (kind < 6) begin
			word = {6'h00, word[25:6], code_pick(int'(rand_bits(4) % 11))};
		end else if (kind < 10) begin
			word = {code_pick(11 + int'(rand_bits(3) % 6)), word[25:0]};
		end else if (kind == 10) begin
			word[31:26] = 6'h03;
		end else if (kind < 14) begin
			word = {6'h1c, word[25:6], 6'h02};
		end
		// Anything else stays a random word, mostly reserved encodings
		instr <= word;
		rega <= rand_bits(32);
		regb <= rand_bits(32);
		in_pc <= rand_bits(30) << 2;
		in_valid <= 1'b1;
	endtask

	////////////////////
	// Reference model
	////////////////////
	function automatic expect_t model_output(input logic [WORD_W-1:0] iw,
			input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
			input logic [WORD_W-1:0] pc);
		expect_t           e;
		logic [WORD_W-1:0] sx;
		logic [WORD_W-1:0] zx;
		sx = {{16{iw[15]}}, iw[15:0]};
		zx = {16'h0000, iw[15:0]};
		e.result = '0;
		e.pc = pc;
		e.legal = 1'b1;
		e.dreg = iw[15:11];
		case (iw[31:26])
			6'h00: begin
				case (iw[5:0])
					6'h00: e.result = b << iw[10:6];
					6'h02: e.result = b >> iw[10:6];
					6'h03: e.result = $signed(b) >>> iw[10:6];
					6'h21: e.result = a + b;
					6'h23: e.result = a - b;
					6'h24: e.result = a & b;
					6'h25: e.result = a | b;
					6'h26: e.result = a ^ b;
					6'h27: e.result = ~(a | b);
					6'h2a: e.result = {31'd0, $signed(a) < $signed(b)};
					6'h2b: e.result = {31'd0, a < b};
					default: e.legal = 1'b0;
				endcase
			end
			6'h1c: begin
				if (iw[5:0] == 6'h02) begin
					e.result = a * b;
				end else begin
					e.legal = 1'b0;
				end
			end
			6'h03: begin
				e.result = pc + 32'd8;
				e.dreg = 5'd31;
			end
			6'h09: e.result = a + sx;
			6'h0a: e.result = {31'd0, $signed(a) < $signed(sx)};
			6'h0c: e.result = a & zx;
			6'h0d: e.result = a | zx;
			6'h0e: e.result = a ^ zx;
			6'h0f: e.result = {iw[15:0], 16'h0000};
			default: e.legal = 1'b0;
		endcase
		// I-type results go to rt
		if (iw[31:26] inside {6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f}) begin
			e.dreg = iw[20:16];
		end
		e.we = e.legal && (e.dreg != 5'd0);
		e.exc = e.legal ? EXC_NONE : EXC_RI;
		return e;
	endfunction

	////////////////////
	// Compare tasks
	////////////////////
	task automatic check_word(input string what, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] want);
		if (got !== want) begin
			err_value++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic check_dreg(input string what, input reg_idx_t got, input reg_idx_t want);
		if (got !== want) begin
			err_value++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic want);
		if (got !== want) begin
			err_value++;
			$display("Fail at %0t: %s is %b, expected %b", $time, what, got, want);
		end
	endtask

	task automatic check_exc(input string what, input exc_code_t got, input exc_code_t want);
		if (got !== want) begin
			err_value++;
			$display("Fail at %0t: %s is %s, expected %s", $time, what, got.name(), want.name());
		end
	endtask

	task automatic check_count(input string what, input int got, input int want);
		if (got != want) begin
			err_value++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	////////////////////
	// Stimulus and scoreboard
	////////////////////
	initial begin
		expect_t e;
		int      cycle;
		int      idle;
		int      retired;
		int      sent;
		int      gap;
		int      mul_cycle;
		logic    mul_watch;
		logic    accepted;
		cycle = 0;
		idle = 0;
		retired = 0;
		sent = 0;
		gap = 0;
		mul_cycle = 0;
		mul_watch = 1'b0;
		err_value = 0;
		err_other = 0;
		lfsr = 32'h32d01e7d;
		rst <= 1'b1;
		in_valid <= 1'b0;
		instr <= '0;
		in_pc <= '0;
		rega <= '0;
		regb <= '0;
		out_ready <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			@(posedge clk);
			// From the second sample on, at least one reset edge has passed
			if (i > 0) begin
				check_bit("out_valid during reset", out_valid, 1'b0);
				check_bit("in_ready during reset", in_ready, 1'b1);
			end
		end
		rst <= 1'b0;

		// Inputs and outputs are sampled at the edge, before it updates anything
		while (retired < N_INSTR && idle < IDLE_LIMIT) begin
			@(posedge clk);
			cycle++;
			idle++;
			if (cycle == 1) begin
				check_bit("out_valid after reset", out_valid, 1'b0);
				check_bit("in_ready after reset", in_ready, 1'b1);
			end
			accepted = in_valid && in_ready;
			// A MUL taken into an empty slot finishes after MUL_CYCLES step edges
			if (mul_watch && out_valid) begin
				check_count("MUL latency in edges", cycle - mul_cycle - 1, MUL_CYCLES);
				mul_watch = 1'b0;
			end
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					err_other++;
					$display("Output retired at %0t with no instruction outstanding", $time);
				end else begin
					e = exp_q.pop_front();
					idle = 0;
					retired++;
					check_word("out_pc", out_pc, e.pc);
					check_bit("we", we, e.we);
					check_exc("exc", exc, e.exc);
					// Result and destination mean nothing for a reserved encoding
					if (e.legal) begin
						check_word("result", result, e.result);
						check_dreg("dreg", dreg, e.dreg);
					end
				end
			end
			if (accepted) begin
				if (!out_valid && instr[31:26] == 6'h1c && instr[5:0] == 6'h02) begin
					mul_watch = 1'b1;
					mul_cycle = cycle;
				end
				exp_q.push_back(model_output(instr, rega, regb, in_pc));
				idle = 0;
				sent++;
				in_valid <= 1'b0;
			end
			if ((accepted || !in_valid) && sent < N_INSTR) begin
				if (gap > 0) begin
					gap--;
				end else begin
					drive_instruction();
					gap = (rand_bits(2) == 0) ? int'(rand_bits(2)) : 0;
				end
			end
			out_ready <= (rand_bits(2) != 0);
		end

		if (idle >= IDLE_LIMIT) begin
			err_other++;
			$display("Timeout: no transfer for %0d cycles, %0d of %0d instructions retired",
				IDLE_LIMIT, retired, N_INSTR);
		end else begin
			for (int i = 0; i < MUL_CYCLES + 4; i++) begin
				@(posedge clk);
				if (out_valid) begin
					err_other++;
					$display("An extra output was offered after the last instruction retired");
					break;
				end
			end
		end
		$display("Errors: %0d wrong values, %0d protocol or timeout", err_value, err_other);
		if (err_value == 0 && err_other == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
verilog/mips_exe_pkg.sv
verilog/inst_decoder.sv
verilog/id_exe_reg.sv
verilog/mul_step_counter.sv
verilog/exe_alu.sv
verilog/exe_stage_ctrl.sv
verilog/exe_slice_top.sv
testbench/tb_exe_slice.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_exe_slice -f project.f -o tb_exe_slice

sim_out=$(./obj_dir/tb_exe_slice)
echo "$sim_out"

if grep -qx "Test completed successfully" <<< "$sim_out"; then
	exit 0
fi
exit 1
